// ==== design/hss_link_pkg.sv ====
`default_nettype none

package hss_link_pkg;

  // ----------------------------------------
  // fixed frame format widths
  // ----------------------------------------
  localparam int PKT_BITS = 32;
  localparam int SEQ_BITS = 7;

  // one packet payload word
  typedef logic [PKT_BITS-1:0] pkt_t;

  // frame sequence number
  typedef logic [SEQ_BITS-1:0] seq_t;

  // frame handed to the serializer
  typedef struct packed {
    seq_t seq;
    pkt_t data;
  } frame_t;

  // ----------------------------------------
  // return word from the remote end
  // ----------------------------------------
  typedef enum logic {
    RTN_ACKNAK = 1'b0,
    RTN_CFC    = 1'b1
  } rtn_kind_e;

  // ack view of the body
  typedef struct packed {
    logic nak;
    seq_t seq;
  } rtn_ack_t;

  // flow control view of the body
  typedef struct packed {
    logic       stop;
    logic [6:0] rsvd;
  } rtn_cfc_t;

  // same 8 bits read two ways depending on kind
  typedef union packed {
    rtn_ack_t ack;
    rtn_cfc_t cfc;
  } rtn_body_u;

  typedef struct packed {
    rtn_kind_e kind;
    rtn_body_u body;
  } rtn_word_t;

endpackage

`default_nettype wire

// ==== design/rtn_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtn_decoder import hss_link_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  // return words from the remote end
  input  wire rtn_word_t rtn_word,
  input  wire logic      rtn_vld,
  // ack/nak strobes and sequence
  output logic           vld_ack,
  output logic           vld_nak,
  output seq_t           ack_seq,
  // remote flow control level
  output logic           cfc_rem
);

  // word classification
  logic is_acknak;
  logic is_cfc;

  always_comb begin
    is_acknak = rtn_vld && (rtn_word.kind == RTN_ACKNAK);
    is_cfc    = rtn_vld && (rtn_word.kind == RTN_CFC);
  end

  // ----------------------------------------
  // ack/nak strobes, one cycle each
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld_ack <= 1'b0;
      vld_nak <= 1'b0;
    end else begin
      vld_ack <= is_acknak && !rtn_word.body.ack.nak;
      vld_nak <= is_acknak && rtn_word.body.ack.nak;
    end
  end

  // sequence only meaningful with a strobe
  always_ff @(posedge clk) begin
    if (is_acknak)
      ack_seq <= rtn_word.body.ack.seq;
  end

  // ----------------------------------------
  // remote flow control
  // ----------------------------------------
  // sending allowed out of reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      cfc_rem <= 1'b1;
    else if (is_cfc)
      cfc_rem <= !rtn_word.body.cfc.stop;
  end

endmodule

`default_nettype wire

// ==== design/pkt_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_store import hss_link_pkg::*; #(
  parameter int BUF_BITS = 3
) (
  input  wire logic clk,
  input  wire logic rst,
  // status only
  // empty means no unread data, unacked data may remain
  output logic      empty,
  output logic      full,
  // remote flow control
  input  wire logic cfc_rem,
  // ack/nak from the return decoder
  input  wire logic vld_ack,
  input  wire logic vld_nak,
  input  wire seq_t ack_seq,
  // incoming packets
  input  wire pkt_t pkt_data,
  input  wire logic pkt_vld,
  output logic      pkt_rdy,
  // buffered packets to frame issue
  input  wire seq_t bpkt_seq,
  output pkt_t      bpkt_data,
  output logic      bpkt_pres,
  input  wire logic bpkt_rq,
  output logic      bpkt_gt
);

  localparam int BUF_LEN = 2 ** BUF_BITS;

  typedef logic [BUF_BITS-1:0] ptr_t;

  // ----------------------------------------
  // pointers
  // ----------------------------------------
  ptr_t ba;   // ack pending
  ptr_t br;   // read
  ptr_t bo;   // output
  ptr_t bw;   // write
  ptr_t nxt_ba;
  ptr_t nxt_br;
  ptr_t nxt_bw;
  ptr_t inc_bw;

  logic nxt_full;
  logic unread;
  logic nxt_unread;
  logic reading;
  logic writing;
  logic nak_q;    // nak strobe seen last cycle

  // resend storage and seq to slot map
  pkt_t pkt_dbuf [BUF_LEN];
  ptr_t seq_map  [BUF_LEN];
  ptr_t seq_to_slot;

  // ----------------------------------------
  // operations this cycle
  // ----------------------------------------
  always_comb begin
    // read granted only with data and remote allowing
    reading = bpkt_rq && unread && cfc_rem;
    writing = pkt_vld && pkt_rdy;
  end

  assign empty = !unread;

  // slot that holds the frame named by ack_seq
  assign seq_to_slot = seq_map[ack_seq[BUF_BITS-1:0]];

  // ----------------------------------------
  // next pointer values
  // ----------------------------------------
  always_comb begin
    nxt_bw = bw;
    if (writing)
      nxt_bw = bw + 1'b1;
  end

  // nak rewinds, grant steps forward
  // a grant right after a nak was read for the old stream
  always_comb begin
    if (vld_nak)
      nxt_br = seq_to_slot;
    else if (bpkt_gt && !nak_q)
      nxt_br = br + 1'b1;
    else
      nxt_br = br;
  end

  // ack_seq is the first frame not yet acked
  // a nak acks everything before it as well
  always_comb begin
    if (vld_nak)
      nxt_ba = seq_to_slot;
    else if (vld_ack && (ack_seq == bpkt_seq))
      nxt_ba = br;  // nothing left pending
    else if (vld_ack)
      nxt_ba = seq_to_slot;
    else
      nxt_ba = ba;
  end

  // keep the compare at pointer width so it wraps
  always_comb begin
    inc_bw     = nxt_bw + 1'b1;
    nxt_full   = (nxt_ba == inc_bw);
    nxt_unread = (nxt_br != nxt_bw);
  end

  // ----------------------------------------
  // control registers
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ba     <= '0;
      br     <= '0;
      bw     <= '0;
      unread <= 1'b0;
      full   <= 1'b0;
      nak_q  <= 1'b0;
    end else begin
      ba     <= nxt_ba;
      br     <= nxt_br;
      bw     <= nxt_bw;
      unread <= nxt_unread;
      full   <= nxt_full;
      nak_q  <= vld_nak;
    end
  end

  // latch slot on each successful read
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      bo <= '0;
    else if (reading)
      bo <= br;
  end

  // ----------------------------------------
  // storage writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (writing)
      pkt_dbuf[bw] <= pkt_data;
  end

  // map written on every request
  // a failed read is retried with the same seq and slot
  always_ff @(posedge clk) begin
    if (bpkt_rq)
      seq_map[bpkt_seq[BUF_BITS-1:0]] <= br;
  end

  // data for the granted read
  assign bpkt_data = pkt_dbuf[bo];

  // ----------------------------------------
  // handshakes
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bpkt_gt   <= 1'b0;
      bpkt_pres <= 1'b0;
      pkt_rdy   <= 1'b0;
    end else begin
      bpkt_gt <= reading;
      // repeats the read result of the last request
      if (bpkt_rq)
        bpkt_pres <= reading;
      pkt_rdy <= !nxt_full;
    end
  end

endmodule

`default_nettype wire

// ==== design/frame_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_issue import hss_link_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  // serializer side
  input  wire logic frame_rdy,
  output frame_t    frame_out,
  output logic      frame_vld,
  // nak rewind
  input  wire logic vld_nak,
  input  wire seq_t ack_seq,
  // packet store side
  output logic      bpkt_rq,
  output seq_t      bpkt_seq,
  input  wire pkt_t bpkt_data,
  input  wire logic bpkt_pres,
  input  wire logic bpkt_gt
);

  // ----------------------------------------
  // internal state
  // ----------------------------------------
  seq_t seq_cnt;    // seq of the next frame
  logic nak_q;      // nak seen last cycle
  logic keep_gt;    // grant belongs to the live stream
  logic nxt_rq;

  // grants during a nak or right after it are from the old stream
  always_comb begin
    keep_gt = bpkt_gt && bpkt_pres && !vld_nak && !nak_q;
  end

  // one request per two cycles
  // store answers in the cycle after each request
  always_comb begin
    nxt_rq = frame_rdy && !bpkt_rq;
  end

  assign bpkt_seq = seq_cnt;

  // ----------------------------------------
  // sequence counter
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      seq_cnt <= '0;
    end else if (vld_nak) begin
      // resend from the nak'd frame
      seq_cnt <= ack_seq;
    end else if (keep_gt) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  // ----------------------------------------
  // request and squash tracking
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bpkt_rq <= 1'b0;
      nak_q   <= 1'b0;
    end else begin
      bpkt_rq <= nxt_rq;
      nak_q   <= vld_nak;
    end
  end

  // ----------------------------------------
  // frame output register
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      frame_vld <= 1'b0;
    else
      frame_vld <= keep_gt;
  end

  // payload only, strobe qualifies it
  always_ff @(posedge clk) begin
    if (keep_gt) begin
      frame_out.seq  <= seq_cnt;
      frame_out.data <= bpkt_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/frame_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_tx_top import hss_link_pkg::*; #(
  parameter int BUF_BITS = 3
) (
  input  wire logic      clk,
  input  wire logic      rst,
  // packet source
  input  wire pkt_t      pkt_data,
  input  wire logic      pkt_vld,
  output logic           pkt_rdy,
  // remote return words
  input  wire rtn_word_t rtn_word,
  input  wire logic      rtn_vld,
  // serializer
  output frame_t         frame_out,
  output logic           frame_vld,
  input  wire logic      frame_rdy,
  // status
  output logic           empty,
  output logic           full
);

  // ----------------------------------------
  // internal nets
  // ----------------------------------------
  logic vld_ack;
  logic vld_nak;
  seq_t ack_seq;
  logic cfc_rem;
  logic bpkt_rq;
  seq_t bpkt_seq;
  pkt_t bpkt_data;
  logic bpkt_pres;
  logic bpkt_gt;

  // return word decode
  rtn_decoder u_rtn_decoder (
    .clk      (clk),
    .rst      (rst),
    .rtn_word (rtn_word),
    .rtn_vld  (rtn_vld),
    .vld_ack  (vld_ack),
    .vld_nak  (vld_nak),
    .ack_seq  (ack_seq),
    .cfc_rem  (cfc_rem)
  );

  // retransmit buffer
  pkt_store #(
    .BUF_BITS (BUF_BITS)
  ) u_pkt_store (
    .clk       (clk),
    .rst       (rst),
    .empty     (empty),
    .full      (full),
    .cfc_rem   (cfc_rem),
    .vld_ack   (vld_ack),
    .vld_nak   (vld_nak),
    .ack_seq   (ack_seq),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .bpkt_seq  (bpkt_seq),
    .bpkt_data (bpkt_data),
    .bpkt_pres (bpkt_pres),
    .bpkt_rq   (bpkt_rq),
    .bpkt_gt   (bpkt_gt)
  );

  // sequencing and frame output
  frame_issue u_frame_issue (
    .clk       (clk),
    .rst       (rst),
    .frame_rdy (frame_rdy),
    .frame_out (frame_out),
    .frame_vld (frame_vld),
    .vld_nak   (vld_nak),
    .ack_seq   (ack_seq),
    .bpkt_rq   (bpkt_rq),
    .bpkt_seq  (bpkt_seq),
    .bpkt_data (bpkt_data),
    .bpkt_pres (bpkt_pres),
    .bpkt_gt   (bpkt_gt)
  );

endmodule

`default_nettype wire

// ==== test/frame_tx_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_tx_asserts #(
  parameter int BUF_BITS = 3
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic pkt_vld,
  input wire logic pkt_rdy,
  input wire logic full,
  input wire logic cfc_rem,
  input wire logic bpkt_rq,
  input wire logic bpkt_gt
);

  // ----------------------------------------
  // store/issue interface rules
  // ----------------------------------------
  // no write into a full store
  no_write_full: assert property (@(posedge clk) disable iff (rst)
    full |-> !(pkt_vld && pkt_rdy))
    else $error("packet written while the store is full");

  // grant only answers a request one cycle earlier
  gt_after_rq: assert property (@(posedge clk) disable iff (rst)
    $rose(bpkt_gt) |-> $past(bpkt_rq))
    else $error("bpkt_gt rose without a request in the previous cycle");

  // read decision was made with the remote allowing
  no_gt_stopped: assert property (@(posedge clk) disable iff (rst)
    bpkt_gt |-> $past(cfc_rem))
    else $error("grant issued while remote flow control was stopped");

  // ready is the inverse of full
  rdy_not_full: assert property (@(posedge clk) disable iff (rst)
    !(pkt_rdy && full))
    else $error("pkt_rdy and full high together");

endmodule

bind pkt_store frame_tx_asserts #(
  .BUF_BITS (BUF_BITS)
) u_frame_tx_asserts (
  .clk     (clk),
  .rst     (rst),
  .pkt_vld (pkt_vld),
  .pkt_rdy (pkt_rdy),
  .full    (full),
  .cfc_rem (cfc_rem),
  .bpkt_rq (bpkt_rq),
  .bpkt_gt (bpkt_gt)
);

`default_nettype wire

// ==== test/frame_tx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_tx_tb import hss_link_pkg::*; ();

  localparam int BUF_BITS   = 3;
  localparam int CAPACITY   = 2 ** BUF_BITS - 1;
  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int SEQ_MOD    = 2 ** SEQ_BITS;
  // test lengths in cycles
  localparam int T_STREAM   = 80;
  localparam int T_FULL     = 80;
  localparam int T_HOLD     = 60;
  localparam int T_MISC     = 60;
  localparam int DRAIN_MAX  = 100;
  localparam int N_DRAINS   = 6;
  localparam int RUN_CYCLES = 8 + T_STREAM + T_FULL + T_HOLD + T_MISC
                              + N_DRAINS * (DRAIN_MAX + 4);

  logic      clk;
  logic      rst;
  pkt_t      pkt_data;
  logic      pkt_vld;
  logic      pkt_rdy;
  rtn_word_t rtn_word;
  logic      rtn_vld;
  frame_t    frame_out;
  logic      frame_vld;
  logic      frame_rdy;
  logic      empty;
  logic      full;

  // remote end model
  pkt_t   hist [256];  // accepted packets by absolute index
  int     n_acc;
  int     push_goal;
  int     base;        // oldest unacked index
  seq_t   exp_seq;     // next seq the serializer should see
  int     n_frames;
  int     err_val;
  int     err_misc;
  integer seed;

  frame_tx_top #(
    .BUF_BITS (BUF_BITS)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .rtn_word  (rtn_word),
    .rtn_vld   (rtn_vld),
    .frame_out (frame_out),
    .frame_vld (frame_vld),
    .frame_rdy (frame_rdy),
    .empty     (empty),
    .full      (full)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic seq_t seq_of(input int idx);
    return seq_t'(idx % SEQ_MOD);
  endfunction

  // seq counted forward from the oldest unacked packet
  function automatic int abs_index(input seq_t seq);
    return base + (int'(seq) - (base % SEQ_MOD) + SEQ_MOD) % SEQ_MOD;
  endfunction

  function automatic pkt_t expected_frame(input seq_t seq);
    return hist[abs_index(seq)];
  endfunction

  // compare every frame where outputs are stable
  always @(negedge clk) begin
    int idx;
    if (!rst && frame_vld) begin
      idx = abs_index(frame_out.seq);
      assert (frame_out.seq == exp_seq) else begin
        $display("Fail at %0t ns: frame seq %0d, expected %0d", $time, frame_out.seq, exp_seq);
        err_val++;
      end
      assert (idx < n_acc && frame_out.data == expected_frame(frame_out.seq)) else begin
        $display("Fail at %0t ns: seq %0d data %h, expected %h", $time, frame_out.seq,
                 frame_out.data, expected_frame(frame_out.seq));
        err_val++;
      end
      exp_seq = frame_out.seq + seq_t'(1);
      n_frames++;
    end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  task automatic check(input logic ok, input string what);
    assert (ok) else begin
      $display("Fail at %0t ns: %s", $time, what);
      err_val++;
    end
  endtask

  // one cycle, acceptance recorded before the edge
  task automatic tick();
    logic took;
    @(negedge clk);
    took = pkt_vld && pkt_rdy;
    if (took) begin
      hist[n_acc] = pkt_data;
      n_acc++;
    end
    @(posedge clk);
    #(DRIVE_DLY);
    rtn_vld = 1'b0;
    if (took)
      pkt_data = $random(seed);
    pkt_vld = (n_acc < push_goal);
  endtask

  task automatic set_goal(input int goal);
    push_goal = goal;
    pkt_vld   = (n_acc < push_goal);
  endtask

  // ack or nak naming packet idx, one cycle strobe
  // old stream frames may still arrive until the nak strobe is decoded
  task automatic send_acknak(input logic nak, input int idx);
    rtn_word.kind         = RTN_ACKNAK;
    rtn_word.body.ack.nak = nak;
    rtn_word.body.ack.seq = seq_of(idx);
    rtn_vld               = 1'b1;
    base                  = idx;
    tick();
    if (nak) begin
      tick();
      exp_seq = seq_of(idx);
    end
  endtask

  task automatic send_cfc(input logic stop);
    rtn_word.kind          = RTN_CFC;
    rtn_word.body.cfc.stop = stop;
    rtn_word.body.cfc.rsvd = '0;
    rtn_vld                = 1'b1;
    tick();
  endtask

  // wait until every accepted packet went out as a frame
  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_seq != seq_of(n_acc) && n < DRAIN_MAX) begin
      tick();
      n++;
    end
    if (exp_seq != seq_of(n_acc)) begin
      $display("frames stopped before all %0d accepted packets were sent", n_acc);
      err_misc++;
    end
    repeat (4) tick();
  endtask

  task automatic settle();
    wait_drain();
    check(empty, "empty with every packet sent");
    send_acknak(1'b0, n_acc);
    repeat (3) tick();
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    int start;
    int f0;
    int n;
    seed      = 32'h9572;
    err_val   = 0;
    err_misc  = 0;
    n_acc     = 0;
    push_goal = 0;
    base      = 0;
    exp_seq   = '0;
    n_frames  = 0;
    rst       = 1'b1;
    pkt_vld   = 1'b0;
    pkt_data  = $random(seed);
    rtn_word  = '0;
    rtn_vld   = 1'b0;
    frame_rdy = 1'b1;
    repeat (4) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;

    // reset state
    check(!frame_vld && !full && empty, "status after reset");
    n = 0;
    while (!pkt_rdy && n < 2) begin
      tick();
      n++;
    end
    check(pkt_rdy, "pkt_rdy low two cycles after reset");

    // steady stream, acked every fourth cycle
    set_goal(n_acc + 20);
    for (int c = 0; c < T_STREAM; c++) begin
      if (c % 4 == 3)
        send_acknak(1'b0, abs_index(exp_seq));
      else
        tick();
    end
    check(n_acc == 20, "stream did not accept all packets");
    settle();
    check(n_frames == 20, "frame count of the stream");

    // fill without acks, then free three slots
    start = n_acc;
    set_goal(start + CAPACITY + 5);
    repeat (T_FULL / 2) tick();
    check(n_acc == start + CAPACITY, "packets accepted before full");
    check(full && !pkt_rdy, "full and pkt_rdy at capacity");
    send_acknak(1'b0, start + 3);
    repeat (T_FULL / 2 - 1) tick();
    check(n_acc == start + CAPACITY + 3, "room after partial ack");
    set_goal(n_acc);
    wait_drain();

    // nak rewinds to start+5 from idle
    // then two naks at opposite request phases while resending
    send_acknak(1'b1, start + 5);
    repeat (4) tick();
    send_acknak(1'b1, start + 6);
    repeat (5) tick();
    send_acknak(1'b1, start + 7);
    f0 = n_frames;
    wait_drain();
    check(n_frames - f0 == n_acc - start - 7, "resent frame count");
    settle();

    // remote stop, at most two in flight
    set_goal(n_acc + 6);
    repeat (4) tick();
    f0 = n_frames;
    send_cfc(1'b1);
    repeat (T_HOLD / 2 - 1) tick();
    check(n_frames - f0 <= 2, "frames after stop word");
    send_cfc(1'b0);
    settle();

    // serializer back-pressure
    set_goal(n_acc + 6);
    repeat (4) tick();
    f0 = n_frames;
    frame_rdy = 1'b0;
    repeat (T_HOLD / 2) tick();
    check(n_frames - f0 <= 2, "frames after frame_rdy low");
    frame_rdy = 1'b1;
    settle();

    $display("errors: %0d value, %0d other", err_val, err_misc);
    if (err_val + err_misc == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // hang guard, twice the summed test length
  initial begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish within %0d cycles", 2 * RUN_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
design/hss_link_pkg.sv
design/rtn_decoder.sv
design/pkt_store.sv
design/frame_issue.sv
design/frame_tx_top.sv
test/frame_tx_asserts.sv
test/frame_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame_tx testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module frame_tx_tb \
  --Mdir obj_dir -o frame_tx_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# simulation output goes to the log, then to the console
./obj_dir/frame_tx_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# verdict comes from the log only
if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
exit 1
